//--- common/task_queue_params.svh
// queue depth, field width and query latency macros
`ifndef TASK_QUEUE_PARAMS_SVH
`define TASK_QUEUE_PARAMS_SVH

// reads in flight
`define MAX_READ        64
`define READ_NUM_WIDTH  6

// ring holds two rounds of every read
`define TASK_RING_DEPTH (2 * `MAX_READ)

// read memory round trip in stall-free cycles
`define QUERY_LAT       3

// task fields
`define STATUS_WIDTH    6
`define BP_POS_WIDTH    7   // up to 101 bases
`define IK_WIDTH        33
`define IK_INFO_WIDTH   14  // two 7-bit halves kept
`define QUERY_WIDTH     8

// occurrence counts from DRAM
`define OCC_CNT_WIDTH   32
`define OCC_WIDE_WIDTH  64

`endif

//--- common/task_queue_pkg.sv
// field typedefs, task status enum, task, query request, response and new read structs
`include "task_queue_params.svh"

package task_queue_pkg;

	typedef logic [`READ_NUM_WIDTH-1:0] read_num_t;
	typedef logic [`BP_POS_WIDTH-1:0]   bp_pos_t;
	typedef logic [`IK_WIDTH-1:0]       ik_val_t;   // compacted bi-interval value
	typedef logic [`IK_INFO_WIDTH-1:0]  ik_info_t;
	typedef logic [`QUERY_WIDTH-1:0]    query_t;    // base symbol from read memory
	typedef logic [`OCC_CNT_WIDTH-1:0]  occ_cnt_t;
	typedef logic [`OCC_WIDE_WIDTH-1:0] occ_wide_t;

	// stage tag carried by every task
	typedef enum logic [`STATUS_WIDTH-1:0] {
		F_INIT  = 6'd0,
		F_RUN   = 6'd1,
		F_BREAK = 6'd2,
		BUBBLE  = 6'h30    // empty slot
	} task_status_t;

	// ========================================
	// one forward task
	typedef struct packed {
		task_status_t status;
		bp_pos_t      ptr_curr;
		read_num_t    read_num;
		ik_val_t      ik_x0;
		ik_val_t      ik_x1;
		ik_val_t      ik_x2;
		ik_info_t     ik_info;
		bp_pos_t      forward_i;
		bp_pos_t      min_intv;
		bp_pos_t      backward_x;
		query_t       query;       // symbol at forward_i, filled by the producer
	} fwd_task_t;

	// symbol fetch toward the read memory
	typedef struct packed {
		bp_pos_t   position;
		read_num_t read_num;
	} query_req_t;

	// one DRAM occurrence response, 4-way counts
	typedef struct packed {
		occ_cnt_t  cnt_a0;
		occ_cnt_t  cnt_a1;
		occ_cnt_t  cnt_a2;
		occ_cnt_t  cnt_a3;
		occ_wide_t cnt_b0;
		occ_wide_t cnt_b1;
		occ_wide_t cnt_b2;
		occ_wide_t cnt_b3;
	} occ_resp_t;

	// fresh read from the loader
	typedef struct packed {
		read_num_t read_num;
		ik_val_t   ik_x0;
		ik_val_t   ik_x1;
		ik_val_t   ik_x2;
		ik_info_t  ik_info;
		bp_pos_t   forward_i;
		bp_pos_t   min_intv;
	} new_read_t;

endpackage

//--- rtl/query_align_pipe.sv
// forward task delay line that joins each task with its returned query symbol
`timescale 1ns/1ps
`include "task_queue_params.svh"

module query_align_pipe (
	input  logic                      Clk_32UI,
	input  logic                      reset_n,
	input  logic                      stall,
	input  task_queue_pkg::fwd_task_t fwd_in,
	input  task_queue_pkg::query_t    query_data,
	output logic                      ring_push,
	output task_queue_pkg::fwd_task_t ring_task
);

	// tasks waiting for the read memory, one per stage
	task_queue_pkg::fwd_task_t stage_q [`QUERY_LAT];
	task_queue_pkg::fwd_task_t join_q;    // task with its symbol attached

	// ========================================
	// delay line
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			for (int i = 0; i < `QUERY_LAT; i++) begin
				stage_q[i].status <= task_queue_pkg::BUBBLE;
			end
			join_q.status <= task_queue_pkg::BUBBLE;
		end else if (!stall) begin
			stage_q[0] <= fwd_in;
			for (int i = 1; i < `QUERY_LAT; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
			// symbol for this task is on query_data now
			join_q       <= stage_q[`QUERY_LAT-1];
			join_q.query <= query_data;
		end
	end

	// ========================================
	// only real forward tasks enter the ring
	always_comb begin
		case (join_q.status)
			task_queue_pkg::F_INIT,
			task_queue_pkg::F_RUN,
			task_queue_pkg::F_BREAK: ring_push = 1'b1;
			default:                 ring_push = 1'b0;  // bubble or unknown tag
		endcase
	end

	assign ring_task = join_q;

endmodule

//--- task_queue/task_ring.sv
// circular forward task ring with wrap-bit pointers and a combinational head
`timescale 1ns/1ps
`include "task_queue_params.svh"

module task_ring (
	input  logic                      Clk_32UI,
	input  logic                      reset_n,
	input  logic                      stall,
	input  logic                      push,
	input  task_queue_pkg::fwd_task_t push_task,
	input  logic                      pop,
	output task_queue_pkg::fwd_task_t head_task,
	output logic                      head_valid
);

	localparam int ADDR_W = $clog2(`TASK_RING_DEPTH);

	task_queue_pkg::fwd_task_t ring_mem [`TASK_RING_DEPTH];

	logic [ADDR_W:0] wr_ptr;   // msb is the wrap bit
	logic [ADDR_W:0] rd_ptr;
	logic            push_en;
	logic            pop_en;

	// nothing moves while stalled
	assign push_en = push && !stall;
	assign pop_en  = pop && !stall && head_valid;

	// ========================================
	// pointers
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// storage, status travels inside the entry
	always_ff @(posedge Clk_32UI) begin
		if (push_en) begin
			ring_mem[wr_ptr[ADDR_W-1:0]] <= push_task;
		end
	end

	// ========================================
	// head view for the consumer
	assign head_valid = (wr_ptr != rd_ptr);
	assign head_task  = ring_mem[rd_ptr[ADDR_W-1:0]];

endmodule

//--- task_queue/occ_resp_fifo.sv
// FIFO of DRAM occurrence-count responses with a registered head
`timescale 1ns/1ps
`include "task_queue_params.svh"

module occ_resp_fifo (
	input  logic                      Clk_32UI,
	input  logic                      reset_n,
	input  logic                      stall,
	input  logic                      wr,
	input  task_queue_pkg::occ_resp_t wr_data,
	input  logic                      pop,
	output logic                      resp_valid,
	output task_queue_pkg::occ_resp_t resp_head
);

	localparam int ADDR_W = $clog2(`MAX_READ);

	task_queue_pkg::occ_resp_t resp_mem [`MAX_READ];

	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;
	logic [ADDR_W:0] rd_ptr_next;  // entry the head register loads
	logic            pop_en;

	assign pop_en      = pop && !stall && resp_valid;
	assign rd_ptr_next = rd_ptr + {{ADDR_W{1'b0}}, pop_en};

	// write side keeps running during stall, DRAM does not wait
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
		end else if (wr) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (wr) begin
			resp_mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
		end
	end

	// ========================================
	// read side
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			rd_ptr     <= '0;
			resp_valid <= 1'b0;
		end else begin
			rd_ptr     <= rd_ptr_next;
			resp_valid <= (wr_ptr != rd_ptr_next);  // entry written at least one edge ago
		end
	end

	always_ff @(posedge Clk_32UI) begin
		resp_head <= resp_mem[rd_ptr_next[ADDR_W-1:0]];
	end

endmodule

//--- rtl/task_dispatch.sv
// consumer choosing break pop, response pop, fresh read or bubble each cycle
`timescale 1ns/1ps

module task_dispatch (
	input  logic                      Clk_32UI,
	input  logic                      reset_n,
	input  logic                      stall,
	input  task_queue_pkg::fwd_task_t head_task,
	input  logic                      head_valid,
	input  logic                      resp_valid,
	input  task_queue_pkg::occ_resp_t resp_head,
	input  logic                      new_read_valid,
	input  task_queue_pkg::new_read_t new_read_in,
	output logic                      ring_pop,
	output logic                      resp_pop,
	output logic                      new_read,
	output task_queue_pkg::fwd_task_t task_out,
	output task_queue_pkg::occ_resp_t occ_out
);

	logic                      break_head;  // leaves without a response
	logic                      run_ready;   // head waits on a count and one is there
	logic                      take_new;
	task_queue_pkg::fwd_task_t fresh_task;

	// ========================================
	// priority decode
	assign break_head = head_valid && (head_task.status == task_queue_pkg::F_BREAK);

	// init tasks wait for their first count like running ones
	assign run_ready = head_valid && resp_valid &&
		((head_task.status == task_queue_pkg::F_RUN) ||
		 (head_task.status == task_queue_pkg::F_INIT));

	assign take_new = new_read_valid && !break_head && !run_ready;

	assign ring_pop = (break_head || run_ready) && !stall;
	assign resp_pop = run_ready && !stall;
	assign new_read = take_new && !stall;

	// first round of a read, no symbol needed yet
	always_comb begin
		fresh_task.status     = task_queue_pkg::F_INIT;
		fresh_task.ptr_curr   = '0;
		fresh_task.read_num   = new_read_in.read_num;
		fresh_task.ik_x0      = new_read_in.ik_x0;
		fresh_task.ik_x1      = new_read_in.ik_x1;
		fresh_task.ik_x2      = new_read_in.ik_x2;
		fresh_task.ik_info    = new_read_in.ik_info;
		fresh_task.forward_i  = new_read_in.forward_i + 1'b1;
		fresh_task.min_intv   = new_read_in.min_intv;
		fresh_task.backward_x = new_read_in.forward_i;  // start of the extension
		fresh_task.query      = '0;
	end

	// ========================================
	// registered result
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			task_out.status <= task_queue_pkg::BUBBLE;
		end else if (!stall) begin
			if (break_head || run_ready) begin
				task_out <= head_task;
			end else if (take_new) begin
				task_out <= fresh_task;
			end else begin
				task_out.status <= task_queue_pkg::BUBBLE;
			end
		end
	end

	// counts only change with a response pop
	always_ff @(posedge Clk_32UI) begin
		if (!stall && run_ready) begin
			occ_out <= resp_head;
		end
	end

endmodule

//--- rtl/read_task_queue.sv
// top level joining the query aligner, task ring, response FIFO and dispatcher
`timescale 1ns/1ps

module read_task_queue (
	input  logic                       Clk_32UI,
	input  logic                       reset_n,
	input  logic                       stall,
	input  logic                       dram_get,
	input  logic                       new_read_valid,
	input  task_queue_pkg::fwd_task_t  fwd_in,
	input  task_queue_pkg::query_req_t query_in,
	input  task_queue_pkg::query_t     query_data,
	input  task_queue_pkg::occ_resp_t  occ_in,
	input  task_queue_pkg::new_read_t  new_read_in,
	output task_queue_pkg::query_req_t query_out,
	output logic                       new_read,
	output task_queue_pkg::fwd_task_t  task_out,
	output task_queue_pkg::occ_resp_t  occ_out
);

	logic                      ring_push;
	task_queue_pkg::fwd_task_t ring_task;
	task_queue_pkg::fwd_task_t head_task;
	logic                      head_valid;
	logic                      ring_pop;
	logic                      resp_valid;
	task_queue_pkg::occ_resp_t resp_head;
	logic                      resp_pop;

	// symbol fetch goes straight to the read memory
	assign query_out = query_in;

	query_align_pipe u_query_align_pipe (
		.Clk_32UI   (Clk_32UI),
		.reset_n    (reset_n),
		.stall      (stall),
		.fwd_in     (fwd_in),
		.query_data (query_data),
		.ring_push  (ring_push),
		.ring_task  (ring_task)
	);

	task_ring u_task_ring (
		.Clk_32UI   (Clk_32UI),
		.reset_n    (reset_n),
		.stall      (stall),
		.push       (ring_push),
		.push_task  (ring_task),
		.pop        (ring_pop),
		.head_task  (head_task),
		.head_valid (head_valid)
	);

	occ_resp_fifo u_occ_resp_fifo (
		.Clk_32UI   (Clk_32UI),
		.reset_n    (reset_n),
		.stall      (stall),
		.wr         (dram_get),
		.wr_data    (occ_in),
		.pop        (resp_pop),
		.resp_valid (resp_valid),
		.resp_head  (resp_head)
	);

	task_dispatch u_task_dispatch (
		.Clk_32UI       (Clk_32UI),
		.reset_n        (reset_n),
		.stall          (stall),
		.head_task      (head_task),
		.head_valid     (head_valid),
		.resp_valid     (resp_valid),
		.resp_head      (resp_head),
		.new_read_valid (new_read_valid),
		.new_read_in    (new_read_in),
		.ring_pop       (ring_pop),
		.resp_pop       (resp_pop),
		.new_read       (new_read),
		.task_out       (task_out),
		.occ_out        (occ_out)
	);

endmodule

//--- bench/tb_read_task_queue_properties.sv
// bound assertions on the read task queue top level
`timescale 1ns/1ps
`include "task_queue_params.svh"

module tb_read_task_queue_properties (
	input logic                      Clk_32UI,
	input logic                      reset_n,
	input logic                      stall,
	input logic                      dram_get,
	input logic                      new_read,
	input task_queue_pkg::fwd_task_t task_out,
	input logic                      ring_push,
	input logic                      ring_pop,
	input task_queue_pkg::fwd_task_t head_task,
	input logic                      resp_valid,
	input logic                      resp_pop
);

	logic [$clog2(`TASK_RING_DEPTH):0] ring_cnt;  // entries held in the ring
	logic [$clog2(`MAX_READ):0]        resp_cnt;  // responses written and not yet popped

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			ring_cnt <= '0;
			resp_cnt <= '0;
		end else begin
			ring_cnt <= ring_cnt + (ring_push && !stall) - ring_pop;
			resp_cnt <= resp_cnt + dram_get - resp_pop;
		end
	end

	// ========================================
	// reset, stall and ring checks
	a_reset_bubble: assert property (@(posedge Clk_32UI)
		!reset_n |=> (task_out.status == task_queue_pkg::BUBBLE))
		else $error("task_out not bubble after a reset edge");

	a_reset_no_new: assert property (@(posedge Clk_32UI) !reset_n |-> !new_read)
		else $error("new_read high during reset");

	a_stall_no_new: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		stall |-> !new_read)
		else $error("new_read high during stall");

	a_no_overflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		(ring_cnt == `TASK_RING_DEPTH) |-> !(ring_push && !stall && !ring_pop))
		else $error("task ring overflow");

	// running task needs a count that DRAM really delivered
	a_run_has_resp: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		(ring_pop && head_task.status == task_queue_pkg::F_RUN) |->
		(resp_valid && resp_cnt != '0))
		else $error("F_RUN task popped without a response");

endmodule

bind read_task_queue tb_read_task_queue_properties u_properties (
	.Clk_32UI   (Clk_32UI),
	.reset_n    (reset_n),
	.stall      (stall),
	.dram_get   (dram_get),
	.new_read   (new_read),
	.task_out   (task_out),
	.ring_push  (ring_push),
	.ring_pop   (ring_pop),
	.head_task  (head_task),
	.resp_valid (resp_valid),
	.resp_pop   (resp_pop)
);

//--- bench/tb_read_task_queue.sv
// testbench with clock, reset, file-driven stimulus, read memory model, reference queues
`timescale 1ns/1ps
`include "task_queue_params.svh"

module tb_read_task_queue;

	logic                       Clk_32UI;
	logic                       reset_n;
	logic                       stall;
	logic                       dram_get;
	logic                       new_read_valid;
	task_queue_pkg::fwd_task_t  fwd_in;
	task_queue_pkg::query_req_t query_in;
	task_queue_pkg::query_t     query_data;
	task_queue_pkg::occ_resp_t  occ_in;
	task_queue_pkg::new_read_t  new_read_in;
	task_queue_pkg::query_req_t query_out;
	logic                       new_read;
	task_queue_pkg::fwd_task_t  task_out;
	task_queue_pkg::occ_resp_t  occ_out;

	task_queue_pkg::query_t     mem_pipe [`QUERY_LAT];  // read memory latency stages

	// reference state
	task_queue_pkg::fwd_task_t  ref_ring_q [$];
	task_queue_pkg::occ_resp_t  ref_resp_q [$];
	task_queue_pkg::fwd_task_t  exp_task_q [$];
	task_queue_pkg::occ_resp_t  exp_occ_q [$];
	logic                       exp_has_occ_q [$];

	int                         mismatch_count;
	int                         other_count;
	integer                     seed;
	logic                       stall_prev;
	task_queue_pkg::fwd_task_t  mon_task;
	task_queue_pkg::occ_resp_t  mon_occ;
	logic                       mon_has_occ;

	read_task_queue u_read_task_queue (.*);

	always #10 Clk_32UI = ~Clk_32UI;

	// ========================================
	// read memory model, symbol is read number xor position
	assign query_data = mem_pipe[`QUERY_LAT-1];

	always @(posedge Clk_32UI) begin
		if (!reset_n) begin
			for (int i = 0; i < `QUERY_LAT; i++) begin
				mem_pipe[i] <= '0;
			end
		end else if (!stall) begin
			mem_pipe[0] <= {2'b00, query_out.read_num} ^ {1'b0, query_out.position};
			for (int i = 1; i < `QUERY_LAT; i++) begin
				mem_pipe[i] <= mem_pipe[i-1];
			end
		end
	end

	// ========================================
	// compare tasks
	task automatic check_task(input string name, input task_queue_pkg::fwd_task_t exp,
			input task_queue_pkg::fwd_task_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("mismatch %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_occ(input string name, input task_queue_pkg::occ_resp_t exp,
			input task_queue_pkg::occ_resp_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("mismatch %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatch_count++;
			$display("mismatch %s: expected %b actual %b", name, exp, act);
		end
	endtask

	function automatic task_queue_pkg::occ_resp_t make_resp(input logic [31:0] s);
		task_queue_pkg::occ_resp_t r;
		r.cnt_a0 = s;
		r.cnt_a1 = s + 1;
		r.cnt_a2 = s + 2;
		r.cnt_a3 = s + 3;
		r.cnt_b0 = {32'h0000_000b, s};
		r.cnt_b1 = {32'h0000_000b, s + 32'd1};
		r.cnt_b2 = {32'h0000_000b, s + 32'd2};
		r.cnt_b3 = {32'h0000_000b, s + 32'd3};
		return r;
	endfunction

	// move every task that may leave ahead of a fresh read into the expected queue
	task automatic drain_ref();
		logic done;
		done = 1'b0;
		while (!done && ref_ring_q.size() > 0) begin
			if (ref_ring_q[0].status == task_queue_pkg::F_BREAK) begin
				exp_task_q.push_back(ref_ring_q.pop_front());
				exp_occ_q.push_back('0);
				exp_has_occ_q.push_back(1'b0);
			end else if (ref_resp_q.size() > 0) begin
				exp_task_q.push_back(ref_ring_q.pop_front());
				exp_occ_q.push_back(ref_resp_q.pop_front());
				exp_has_occ_q.push_back(1'b1);
			end else begin
				done = 1'b1;   // running head waits on DRAM
			end
		end
	endtask

	task automatic step();
		@(posedge Clk_32UI);
		#2;
	endtask

	// ========================================
	// output monitor, one check per stall-free edge
	always @(negedge Clk_32UI) begin
		if (reset_n && !stall_prev && task_out.status != task_queue_pkg::BUBBLE) begin
			drain_ref();  // ring tasks leave as soon as they are eligible
			if (exp_task_q.size() == 0) begin
				other_count++;
				$display("task for read %h came out with nothing expected", task_out.read_num);
			end else begin
				mon_task    = exp_task_q.pop_front();
				mon_occ     = exp_occ_q.pop_front();
				mon_has_occ = exp_has_occ_q.pop_front();
				check_task("dispatch order", mon_task, task_out);
				if (mon_has_occ) begin
					check_occ("response order", mon_occ, occ_out);
				end
			end
		end
		stall_prev = stall;
	end

	initial begin
		integer fd;
		integer rc;
		integer gap;
		integer t;
		logic [7:0] op;
		logic [63:0] f1, f2, f3, f4, f5;
		string skip;
		task_queue_pkg::fwd_task_t tsk;
		task_queue_pkg::fwd_task_t held_task;
		task_queue_pkg::occ_resp_t held_occ;

		seed = 5064;
		mismatch_count = 0;
		other_count = 0;
		stall_prev = 1'b0;
		Clk_32UI = 1'b0;
		reset_n = 1'b0;
		stall = 1'b0;
		dram_get = 1'b0;
		new_read_valid = 1'b0;
		fwd_in = '0;
		fwd_in.status = task_queue_pkg::BUBBLE;
		query_in = '0;
		occ_in = '0;
		new_read_in = '0;
		repeat (10) @(posedge Clk_32UI);
		#2 reset_n = 1'b1;

		// quiet after reset
		repeat (3) begin
			@(negedge Clk_32UI);
			check_bit("reset bubble", 1'b1, task_out.status == task_queue_pkg::BUBBLE);
			check_bit("reset new_read", 1'b0, new_read);
		end

		fd = $fopen("bench/task_queue_testdata.txt", "r");
		if (fd == 0) begin
			other_count++;
			$display("cannot open the stimulus file");
		end else begin
			while ($fscanf(fd, " %c", op) == 1) begin
				case (op)
					"#": rc = $fgets(skip, fd);
					"P": begin
						rc = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
						tsk = '0;
						tsk.status    = task_queue_pkg::task_status_t'(f1[5:0]);
						tsk.read_num  = f2[5:0];
						tsk.ptr_curr  = f3[6:0];
						tsk.forward_i = f3[6:0];
						tsk.ik_x0     = f4[32:0];
						tsk.ik_x1     = f4[32:0] + 1;
						tsk.ik_x2     = f4[32:0] + 2;
						tsk.ik_info   = {8'h0, f2[5:0]};
						tsk.min_intv  = 7'd1;
						tsk.query     = 8'hee;  // overwritten by the symbol
						step();
						fwd_in = tsk;
						query_in.position = f3[6:0];
						query_in.read_num = f2[5:0];
						step();
						fwd_in.status = task_queue_pkg::BUBBLE;
						tsk.query = f5[7:0];
						ref_ring_q.push_back(tsk);
						repeat (`QUERY_LAT + 1) step();   // until it sits in the ring
					end
					"D": begin
						rc = $fscanf(fd, "%h", f1);
						step();
						dram_get = 1'b1;
						occ_in = make_resp(f1[31:0]);
						ref_resp_q.push_back(occ_in);
						step();
						dram_get = 1'b0;
					end
					"N": begin
						rc = $fscanf(fd, "%h %h %h", f1, f2, f3);
						drain_ref();
						step();
						new_read_in = '0;
						new_read_in.read_num  = f1[5:0];
						new_read_in.forward_i = f2[6:0];
						new_read_in.ik_x0     = 33'h1_0000_0000 | f1[5:0];
						new_read_in.ik_x1     = 33'h55;
						new_read_in.ik_x2     = 33'h66;
						new_read_in.ik_info   = 14'h2a;
						new_read_in.min_intv  = 7'd2;
						tsk = '0;
						tsk.status     = task_queue_pkg::F_INIT;
						tsk.read_num   = f1[5:0];
						tsk.ik_x0      = new_read_in.ik_x0;
						tsk.ik_x1      = 33'h55;
						tsk.ik_x2      = 33'h66;
						tsk.ik_info    = 14'h2a;
						tsk.forward_i  = f3[6:0];
						tsk.min_intv   = 7'd2;
						tsk.backward_x = f2[6:0];
						exp_task_q.push_back(tsk);
						exp_occ_q.push_back('0);
						exp_has_occ_q.push_back(1'b0);
						new_read_valid = 1'b1;
						for (t = 0; t < 200 && !new_read; t++) begin
							@(negedge Clk_32UI);
						end
						if (!new_read) begin
							other_count++;
							$display("fresh read %h was never taken", f1[5:0]);
						end
						step();
						new_read_valid = 1'b0;
						@(negedge Clk_32UI);
						check_bit("new_read pulse", 1'b0, new_read);
					end
					"S": begin
						rc = $fscanf(fd, "%h %h %h", f1, f2, f3);
						step();
						stall = 1'b1;
						new_read_valid = 1'b1;   // offered, must not be taken while stalled
						held_task = task_out;
						held_occ = occ_out;
						for (t = 0; t < f1; t++) begin
							dram_get = (t < f2);
							if (t < f2) begin
								occ_in = make_resp(f3[31:0] + t);
								ref_resp_q.push_back(occ_in);
							end
							@(negedge Clk_32UI);
							check_task("stall task hold", held_task, task_out);
							check_occ("stall occ hold", held_occ, occ_out);
							check_bit("stall new_read", 1'b0, new_read);
							step();
						end
						stall = 1'b0;
						new_read_valid = 1'b0;
						dram_get = 1'b0;
					end
					"I": begin
						rc = $fscanf(fd, "%h", f1);
						gap = f1 + ($random(seed) & 3);
						repeat (gap) step();
					end
					default: begin
						other_count++;
						$display("unknown opcode in the stimulus file");
					end
				endcase
			end
			$fclose(fd);
		end

		drain_ref();
		for (t = 0; t < 500 && exp_task_q.size() > 0; t++) begin
			@(negedge Clk_32UI);
		end
		if (exp_task_q.size() > 0) begin
			other_count++;
			$display("timeout, %0d expected tasks never came out", exp_task_q.size());
		end
		if (ref_ring_q.size() > 0) begin
			other_count++;
			$display("%0d running tasks left without a response", ref_ring_q.size());
		end

		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- bench/task_queue_testdata.txt
# P status read_num pos ik0 exp_query | D seed | N read_num fwd_i exp_fwd_i
# S cycles writes seed | I cycles      (all fields hex)
N 05 10 11
I 2
P 2 03 0a 100 09
P 2 07 21 101 26
P 2 3f 64 102 5b
I 4
P 1 01 05 110 04
P 1 02 06 111 04
I 2
N 08 20 21
D 1000
D 2000
I 4
P 1 09 0c 120 05
I 2
S 5 2 3000
P 1 0a 0d 121 07
I 3
P 1 0d 40 140 4d
P 2 0e 41 141 4f
N 0f 50 51
D 4000
I 4
P 1 11 60 160 71
P 2 12 61 161 73
P 2 13 62 162 71
D 5000
N 14 70 71
I 6

//--- vlog.f
+incdir+common
common/task_queue_pkg.sv
rtl/query_align_pipe.sv
task_queue/task_ring.sv
task_queue/occ_resp_fifo.sv
rtl/task_dispatch.sv
rtl/read_task_queue.sv
bench/tb_read_task_queue_properties.sv
bench/tb_read_task_queue.sv
